// ==== Makefile ====
# Verilator build and run for the cordic unit testbench

VERILATOR ?= verilator
TOP       ?= cordic_unit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cordic_unit_tb.sv ====
// cordic unit testbench
`timescale 1ns/1ns

module cordic_unit_tb
    import cordic_pkg::*;
();
    localparam int DATA_W       = 16;
    localparam int FRAC_W       = 12;
    localparam int ITERATIONS   = 14;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam real TOL_LSB     = 3.0;
    localparam logic [31:0] SEED = 32'hed6b_03a3;

    // request counts per phase
    localparam int N_SQRT = 24;  // plus 3 fixed radicands
    localparam int N_COS  = 24;  // plus 3 fixed angles
    localparam int N_MIX  = 24;
    localparam int N_BP   = 30;
    localparam int N_REQ  = N_SQRT + 3 + N_COS + 3 + N_MIX + N_BP;
    localparam int WATCHDOG_CYCLES = N_REQ * 40 + 200;

    typedef struct packed {
        cordic_op_t        op;
        logic [DATA_W-1:0] word;
    } req_t;

    logic              clk;
    logic              rst;
    logic              in_valid;
    cordic_op_t        in_op;
    logic [DATA_W-1:0] in_operand;
    logic              in_ready;
    logic              out_valid;
    logic [DATA_W-1:0] out_a;
    logic [DATA_W-1:0] out_b;
    logic              out_ready;

    req_t        exp_q[$];      // accepted requests, oldest first
    int          n_sent;
    int          n_recv;
    logic [31:0] rnd_state;     // operand stream
    logic [31:0] bp_state;      // back-pressure stream
    int          bp_left;       // cycles left in the current out_ready stretch
    logic        bp_on;
    logic        saw_full;      // in_ready low while the output is stalled

    cordic_unit #(
        .DATA_W     (DATA_W),
        .FRAC_W     (FRAC_W),
        .ITERATIONS (ITERATIONS)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_operand (in_operand),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_a      (out_a),
        .out_b      (out_b),
        .out_ready  (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    // raw Q4.12 in [1/16, 15]
    function automatic logic [DATA_W-1:0] random_radicand();
        return DATA_W'(next_random() % 32'd61185 + 32'd256);
    endfunction

    // raw Q4.12 in [-pi/2, pi/2], pi/2 is 6433.98 lsb
    function automatic logic [DATA_W-1:0] random_angle();
        int a;
        a = int'(next_random() % 32'd12867) - 6433;
        return DATA_W'(a);
    endfunction

    function automatic real lsb_error(input real got, input real want);
        real d;
        d = got - want;
        return (d < 0.0) ? -d : d;
    endfunction

    // ideal results in lsb units of Q4.12
    task automatic compute_reference(input cordic_op_t op, input logic [DATA_W-1:0] word,
                                     output real a, output real b);
        real scale;
        real v;
        scale = real'(1 << FRAC_W);
        if (op == OP_SQRT)
        begin
            v = real'(word) / scale;
            a = $sqrt(v) * scale;
            b = 0.0;
        end
        else
        begin
            v = real'($signed(word)) / scale;
            a = $cos(v) * scale;
            b = $sin(v) * scale;
        end
    endtask

    // called at posedge+2, returns at posedge+2 after the transfer
    task automatic send_request(input cordic_op_t op, input logic [DATA_W-1:0] word);
        in_valid   = 1'b1;
        in_op      = op;
        in_operand = word;
        do
            @(posedge clk);
        while (!in_ready);
        exp_q.push_back('{op: op, word: word});
        n_sent++;
        #2;
        in_valid = 1'b0;
    endtask

    task automatic send_mixed(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++)
        begin
            r = next_random();
            if (r[7])
                send_request(OP_COSSIN, random_angle());
            else
                send_request(OP_SQRT, random_radicand());
        end
    endtask

    task automatic wait_for_results();
        wait (n_recv == n_sent);
        @(posedge clk);
        #2;
    endtask

    // held output must not move until taken
    property output_held;
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_a) && $stable(out_b);
    endproperty

    assert property (output_held)
        else stop_run($sformatf("[ERROR] %0t: output changed or dropped while stalled", $time));

    // compare every taken result against the oldest outstanding request
    always @(posedge clk)
    begin : check_outputs
        req_t req;
        real  ea;
        real  eb;
        real  got_a;
        real  got_b;
        if (!rst && out_valid && out_ready)
        begin
            assert (exp_q.size() != 0)
                else stop_run("a result came out with no request outstanding");
            req = exp_q.pop_front();
            n_recv++;
            compute_reference(req.op, req.word, ea, eb);
            got_a = (req.op == OP_SQRT) ? real'(out_a) : real'($signed(out_a));
            got_b = real'($signed(out_b));
            assert (lsb_error(got_a, ea) <= TOL_LSB)
                else stop_run($sformatf("[ERROR] %0t: %s of 0x%h gave out_a %0d, expected %.2f",
                                        $time, req.op.name(), req.word, out_a, ea));
            if (req.op == OP_SQRT)
            begin
                assert (out_b == '0)
                    else stop_run($sformatf(
                        "[ERROR] %0t: sqrt of 0x%h gave out_b %0d, expected 0",
                        $time, req.word, out_b));
            end
            else
            begin
                assert (lsb_error(got_b, eb) <= TOL_LSB)
                    else stop_run($sformatf(
                        "[ERROR] %0t: sine of 0x%h gave out_b %0d, expected %.2f",
                        $time, req.word, $signed(out_b), eb));
            end
        end
    end

    // random stretches of out_ready, low ones longer
    always @(posedge clk)
    begin : drive_out_ready
        logic stall_phase;  // bp_on as it stood at the edge
        stall_phase = bp_on;
        #2;
        if (!stall_phase)
            out_ready = 1'b1;
        else if (bp_left != 0)
            bp_left = bp_left - 1;
        else
        begin
            bp_state  = xorshift32(bp_state);
            out_ready = bp_state[8];
            bp_left   = out_ready ? int'(bp_state[3:2]) : int'(bp_state[5:2]);
        end
    end

    always @(posedge clk)
    begin
        if (!rst && in_valid && !in_ready && out_valid && !out_ready)
            saw_full = 1'b1;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES + RESET_CYCLES) @(posedge clk);
        stop_run($sformatf("watchdog expired, %0d of %0d results received", n_recv, n_sent));
    end

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_op      = OP_SQRT;
        in_operand = '0;
        out_ready  = 1'b1;
        n_sent     = 0;
        n_recv     = 0;
        bp_on      = 1'b0;
        bp_left    = 0;
        saw_full   = 1'b0;
        rnd_state  = SEED;
        bp_state   = xorshift32(~SEED);  // separate stream

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        assert (!out_valid && in_ready)
            else stop_run($sformatf("[ERROR] %0t: after reset out_valid=%b in_ready=%b",
                                    $time, out_valid, in_ready));
        #2;

        // square root, zero and both range ends first
        send_request(OP_SQRT, '0);
        send_request(OP_SQRT, DATA_W'(256));
        send_request(OP_SQRT, DATA_W'(61440));
        for (int i = 0; i < N_SQRT; i++)
            send_request(OP_SQRT, random_radicand());
        wait_for_results();

        // cosine and sine, edges of the angle range
        send_request(OP_COSSIN, '0);
        send_request(OP_COSSIN, DATA_W'(6433));
        send_request(OP_COSSIN, DATA_W'(-6433));
        for (int i = 0; i < N_COS; i++)
            send_request(OP_COSSIN, random_angle());
        wait_for_results();

        send_mixed(N_MIX);  // back to back, out_ready high
        wait_for_results();

        bp_on    = 1'b1;
        saw_full = 1'b0;
        send_mixed(N_BP);
        wait_for_results();
        bp_on = 1'b0;
        assert (saw_full)
            else stop_run("in_ready never fell while out_ready was held low");

        repeat (20) @(posedge clk);  // any stray result would trip the checker

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== src/cordic_decode.sv ====
// cordic request decode
`timescale 1ns/1ns

module cordic_decode
    import cordic_pkg::*;
#(
    parameter int DATA_W = DATA_W_DEF,
    parameter int FRAC_W = FRAC_W_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  cordic_op_t in_op,
    input  operand_u   in_operand,
    output logic       in_ready,
    cordic_start_if.source start
);
    localparam int IW   = DATA_W + GUARD_W;
    localparam int IF   = FRAC_W + GUARD_W;      // internal fraction bits
    localparam int SH_W = $clog2(DATA_W + 1);

    localparam logic signed [IW-1:0] QUARTER = IW'(longint'(1) <<< (IF - 2));
    localparam logic signed [IW-1:0] CIRC_Q  = IW'(align_frac(CIRC_GAIN, CONST_FRAC_W, IF));

    logic [SH_W-1:0]      msb;      // leading one of the radicand
    logic [SH_W-1:0]      lz;       // leading zeros
    logic [SH_W-1:0]      sh;       // lz rounded up to even
    logic [DATA_W:0]      norm;     // radicand as a fraction, times 2^sh
    logic signed [IW-1:0] v_int;
    logic signed [IW-1:0] x_d;
    logic signed [IW-1:0] y_d;
    logic signed [IW-1:0] z_d;
    logic [SH_W-1:0]      shift_d;
    logic                 accept;

    // one slot, refilled in the same cycle it drains
    assign in_ready = !start.valid || start.ready;
    assign accept   = in_valid && in_ready;

    always_comb
    begin
        msb = '0;
        for (int i = 0; i < DATA_W; i++)
        begin
            if (in_operand.radicand[i])
            begin
                msb = SH_W'(i);  // last hit is the highest set bit
            end
        end
        lz   = SH_W'(DATA_W - 1) - msb;
        sh   = lz[0] ? lz + 1'b1 : lz;  // even, so the root shift is whole
        norm = {1'b0, in_operand.radicand} << sh;  // lands in [0.5, 2)
        v_int = IW'(align_frac(longint'(norm), DATA_W, IF));

        if (in_op == OP_SQRT)
        begin
            z_d = '0;
            if (in_operand.radicand == '0)
            begin
                x_d     = '0;  // zero vector stays zero in the kernel
                y_d     = '0;
                shift_d = '0;
            end
            else
            begin
                x_d     = v_int + QUARTER;  // v + 0.25
                y_d     = v_int - QUARTER;  // v - 0.25
                shift_d = sh;
            end
        end
        else
        begin
            x_d     = CIRC_Q;  // gain preloaded, no multiply at the end
            y_d     = '0;
            z_d     = IW'(align_frac(longint'(in_operand.angle), FRAC_W, IF));
            shift_d = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            start.valid <= 1'b0;
        else if (accept)
            start.valid <= 1'b1;
        else if (start.ready)
            start.valid <= 1'b0;  // taken by the kernel
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            start.mode  <= in_op;
            start.x     <= x_d;
            start.y     <= y_d;
            start.z     <= z_d;
            start.shift <= shift_d;
        end
    end

endmodule

// ==== src/cordic_if.sv ====
// cordic stage links
`timescale 1ns/1ns

// start vector, decode to kernel
interface cordic_start_if
    import cordic_pkg::*;
#(
    parameter int DATA_W = DATA_W_DEF
) ();
    localparam int IW   = DATA_W + GUARD_W;      // internal width
    localparam int SH_W = $clog2(DATA_W + 1);    // shift can reach DATA_W

    logic                 valid;
    logic                 ready;
    cordic_op_t           mode;
    logic signed [IW-1:0] x;
    logic signed [IW-1:0] y;
    logic signed [IW-1:0] z;      // residual angle, rotation only
    logic [SH_W-1:0]      shift;  // even normalization shift of the radicand

    modport source (output valid, output mode, output x, output y, output z,
                    output shift, input ready);
    modport sink   (input valid, input mode, input x, input y, input z,
                    input shift, output ready);
endinterface

// finished vector, kernel to result
interface cordic_done_if
    import cordic_pkg::*;
#(
    parameter int DATA_W = DATA_W_DEF
) ();
    localparam int IW   = DATA_W + GUARD_W;
    localparam int SH_W = $clog2(DATA_W + 1);

    logic                 valid;
    logic                 ready;
    cordic_op_t           mode;
    logic signed [IW-1:0] x;      // scaled root or cosine
    logic signed [IW-1:0] y;      // sine, residue for sqrt
    logic [SH_W-1:0]      shift;  // carried through from decode

    modport source (output valid, output mode, output x, output y,
                    output shift, input ready);
    modport sink   (input valid, input mode, input x, input y,
                    input shift, output ready);
endinterface

// ==== src/cordic_kernel.sv ====
// iterative cordic engine
`timescale 1ns/1ns

module cordic_kernel
    import cordic_pkg::*;
#(
    parameter int DATA_W     = DATA_W_DEF,
    parameter int FRAC_W     = FRAC_W_DEF,
    parameter int ITERATIONS = 14
) (
    input  logic clk,
    input  logic rst,
    cordic_start_if.sink   start,
    cordic_done_if.source  done
);
    localparam int IW    = DATA_W + GUARD_W;
    localparam int IF    = FRAC_W + GUARD_W;
    localparam int SH_W  = $clog2(DATA_W + 1);
    localparam int IDX_W = $clog2(ITERATIONS + 1);
    localparam int K_W   = $clog2(3 * ITERATIONS + 2);  // holds the next 3k+1

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITER,
        ST_HOLD
    } state_t;

    state_t               state;
    cordic_op_t           mode;
    logic signed [IW-1:0] x;
    logic signed [IW-1:0] y;
    logic signed [IW-1:0] z;
    logic [SH_W-1:0]      shift;
    logic [IDX_W-1:0]     idx;   // current shift index
    logic [K_W-1:0]       k;     // next index to repeat, 4, 13, 40 ...
    logic                 rep;   // current index already done once

    logic signed [IW-1:0] x_sh;
    logic signed [IW-1:0] y_sh;
    logic signed [IW-1:0] atan_q;
    logic signed [IW-1:0] x_nxt;
    logic signed [IW-1:0] y_nxt;
    logic signed [IW-1:0] z_nxt;
    logic                 hyper;
    logic                 dir_neg;
    logic                 repeat_now;
    logic                 last_step;
    logic                 accept;

    // atan(2^-i), 16 fraction bits, then moved to the internal format
    function automatic logic signed [IW-1:0] atan_lut(input logic [IDX_W-1:0] i);
        longint a;
        case (i)
            0: a = 51472;
            1: a = 30385;
            2: a = 16055;
            3: a = 8150;
            4: a = 4091;
            5: a = 2047;
            6: a = 1024;
            7: a = 512;
            8: a = 256;
            default: a = (i <= CONST_FRAC_W) ? (longint'(1) << (CONST_FRAC_W - i)) : 0;
        endcase
        return IW'(align_frac(a, CONST_FRAC_W, IF));
    endfunction

    assign start.ready = (state == ST_IDLE);
    assign accept      = start.valid && start.ready;

    assign hyper   = (mode == OP_SQRT);
    assign dir_neg = hyper ? y[IW-1] : z[IW-1];  // drive y or z toward zero
    assign x_sh    = x >>> idx;
    assign y_sh    = y >>> idx;
    assign atan_q  = atan_lut(idx);

    assign repeat_now = hyper && (K_W'(idx) == k) && !rep;
    assign last_step  = (idx == (hyper ? IDX_W'(ITERATIONS) : IDX_W'(ITERATIONS - 1)))
                        && !repeat_now;

    always_comb
    begin
        x_nxt = dir_neg ? x + y_sh : x - y_sh;
        if (hyper)
        begin
            y_nxt = dir_neg ? y + x_sh : y - x_sh;
            z_nxt = z;  // no angle in vectoring
        end
        else
        begin
            y_nxt = dir_neg ? y - x_sh : y + x_sh;
            z_nxt = dir_neg ? z + atan_q : z - atan_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            idx   <= '0;
            k     <= '0;
            rep   <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        state <= ST_ITER;
                        idx   <= (start.mode == OP_SQRT) ? IDX_W'(1) : '0;  // no index 0 in hyperbolic
                        k     <= K_W'(4);
                        rep   <= 1'b0;
                    end
                end
                ST_ITER:
                begin
                    if (last_step)
                        state <= ST_HOLD;
                    if (repeat_now)
                    begin
                        rep <= 1'b1;  // same index once more
                    end
                    else
                    begin
                        idx <= idx + 1'b1;
                        rep <= 1'b0;
                        if (hyper && K_W'(idx) == k)
                            k <= K_W'(3 * k + 1);
                    end
                end
                ST_HOLD:
                begin
                    if (done.ready)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            mode  <= start.mode;
            x     <= start.x;
            y     <= start.y;
            z     <= start.z;
            shift <= start.shift;
        end
        else if (state == ST_ITER)
        begin
            x <= x_nxt;
            y <= y_nxt;
            z <= z_nxt;
        end
    end

    assign done.valid = (state == ST_HOLD);
    assign done.mode  = mode;
    assign done.x     = x;
    assign done.y     = y;
    assign done.shift = shift;

endmodule

// ==== src/cordic_pkg.sv ====
// cordic shared types and constants
package cordic_pkg;

    // default word format, unsigned or signed Q4.12
    localparam int DATA_W_DEF = 16;
    localparam int FRAC_W_DEF = 12;

    // extra low-order bits carried through the kernel
    localparam int GUARD_W = 4;

    // fraction bits of the fixed-point constants below
    localparam int CONST_FRAC_W = FRAC_W_DEF + GUARD_W;

    typedef enum logic {
        OP_SQRT   = 1'b0,  // hyperbolic vectoring
        OP_COSSIN = 1'b1   // circular rotation
    } cordic_op_t;

    // one request word, read as radicand or as angle depending on the opcode
    typedef union packed {
        logic        [DATA_W_DEF-1:0] radicand;  // unsigned Q4.12
        logic signed [DATA_W_DEF-1:0] angle;     // signed Q4.12 radians, within +-pi/2
    } operand_u;

    // circular start value, 1/K for 14 rotations, about 0.607253
    localparam logic signed [DATA_W_DEF+GUARD_W-1:0] CIRC_GAIN =
        (DATA_W_DEF + GUARD_W)'(39797);

    // 1/K of hyperbolic vectoring with the 4 and 13 repeats, about 1.2075
    localparam logic signed [DATA_W_DEF+GUARD_W-1:0] HYP_GAIN_INV =
        (DATA_W_DEF + GUARD_W)'(79134);

    // moves a fixed-point value from from_w to to_w fraction bits
    function automatic longint align_frac(
        input longint v,
        input int     from_w,
        input int     to_w
    );
        if (to_w >= from_w)
        begin
            return v <<< (to_w - from_w);
        end
        return v >>> (from_w - to_w);  // truncates toward minus infinity
    endfunction

endpackage

// ==== src/cordic_result.sv ====
// cordic result stage
`timescale 1ns/1ns

module cordic_result
    import cordic_pkg::*;
#(
    parameter int DATA_W = DATA_W_DEF,
    parameter int FRAC_W = FRAC_W_DEF
) (
    input  logic              clk,
    input  logic              rst,
    cordic_done_if.sink       done,
    input  logic              out_ready,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_a,
    output logic [DATA_W-1:0] out_b
);
    localparam int IW       = DATA_W + GUARD_W;
    localparam int IF       = FRAC_W + GUARD_W;
    localparam int PW       = 2 * IW;                 // product width
    localparam int HALF_INT = (DATA_W - FRAC_W) / 2;  // radicand integer bits, halved

    localparam logic signed [IW-1:0] HYP_Q = IW'(align_frac(HYP_GAIN_INV, CONST_FRAC_W, IF));

    // product has 2*IF fraction bits, output wants FRAC_W,
    // and the root of the fraction-scaled radicand is 2^HALF_INT too small
    localparam int BASE_SH = IF + GUARD_W - HALF_INT;

    logic signed [PW-1:0] prod;
    logic signed [PW-1:0] root;
    logic [DATA_W-1:0]    a_d;
    logic [DATA_W-1:0]    b_d;
    logic                 accept;

    assign done.ready = !out_valid || out_ready;  // free or draining now
    assign accept     = done.valid && done.ready;

    assign prod = done.x * HYP_Q;                       // undo hyperbolic gain
    assign root = prod >>> (BASE_SH + (done.shift >> 1));  // half the normalization shift

    always_comb
    begin
        if (done.mode == OP_SQRT)
        begin
            a_d = root[DATA_W-1:0];  // below 4.0, fits unsigned Q4.12
            b_d = '0;
        end
        else
        begin
            // gain was preloaded, just drop the guard bits
            a_d = done.x[IW-1:GUARD_W];
            b_d = done.y[IW-1:GUARD_W];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            out_valid <= 1'b0;
        else if (accept)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;  // consumer took it
    end

    // held until the consumer takes it
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out_a <= a_d;
            out_b <= b_d;
        end
    end

endmodule

// ==== src/cordic_unit.sv ====
// cordic math unit top
`timescale 1ns/1ns

module cordic_unit
    import cordic_pkg::*;
#(
    parameter int DATA_W     = DATA_W_DEF,
    parameter int FRAC_W     = FRAC_W_DEF,
    parameter int ITERATIONS = 14
) (
    input  logic              clk,
    input  logic              rst,

    // request stream
    input  logic              in_valid,
    input  cordic_op_t        in_op,
    input  logic [DATA_W-1:0] in_operand,  // radicand or angle
    output logic              in_ready,

    // result stream
    output logic              out_valid,
    output logic [DATA_W-1:0] out_a,       // root or cosine
    output logic [DATA_W-1:0] out_b,       // sine, zero for sqrt
    input  logic              out_ready
);

    cordic_start_if #(.DATA_W(DATA_W)) start_if ();  // decode to kernel
    cordic_done_if  #(.DATA_W(DATA_W)) done_if ();   // kernel to result

    cordic_decode #(
        .DATA_W     (DATA_W),
        .FRAC_W     (FRAC_W)
    ) u_decode (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_operand (in_operand),
        .in_ready   (in_ready),
        .start      (start_if)
    );

    cordic_kernel #(
        .DATA_W     (DATA_W),
        .FRAC_W     (FRAC_W),
        .ITERATIONS (ITERATIONS)
    ) u_kernel (
        .clk        (clk),
        .rst        (rst),
        .start      (start_if),
        .done       (done_if)
    );

    cordic_result #(
        .DATA_W     (DATA_W),
        .FRAC_W     (FRAC_W)
    ) u_result (
        .clk        (clk),
        .rst        (rst),
        .done       (done_if),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_a      (out_a),
        .out_b      (out_b)
    );

endmodule

// ==== tb.f ====
src/cordic_pkg.sv
src/cordic_if.sv
src/cordic_decode.sv
src/cordic_kernel.sv
src/cordic_result.sv
src/cordic_unit.sv
bench/cordic_unit_tb.sv
